// ==== Makefile ====
# Verilator flow for the sigma-delta front end testbench.
# Any variable below can be overridden on the command line.

VERILATOR  ?= verilator
TOP        ?= sd_processor_tb
RTL_TOP    ?= sd_processor
FILELIST   ?= build.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= Finished with no errors
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The simulation log decides the result, not the exit status
run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== build.f ====
logic/sd_pkg.sv
logic/sd_clock_gen.sv
logic/sd_cic_decimator.sv
logic/sd_processor.sv
testbench/sd_processor_properties.sv
testbench/sd_processor_tb.sv

// ==== logic/sd_cic_decimator.sv ====
////////////////////////////////////////////////////////////////////////////
// One channel of the front end: bit synchronizer, third-order CIC
// decimator and output register. Strobes come from the clock generator.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sd_cic_decimator (
    input  logic            clock,
    input  logic            reset,
    input  logic            data_in,
    input  logic            bit_strobe,
    input  logic            frame_strobe,
    input  logic            comb_clear,
    output sd_pkg::sample_t sample,
    output logic            sample_valid
);

    import sd_pkg::*;

    // Two-flop synchronizer for the asynchronous modulator bit
    logic [1:0] data_sync;

    // Synchronized bit mapped to plus or minus one
    cic_word_t bit_value;

    // Cascaded integrators, stage 0 takes the mapped bit
    cic_word_t integ [CIC_ORDER];

    // Comb delay registers hold each stage input from the previous frame
    cic_word_t comb_delay [CIC_ORDER];

    // Comb chain, entry 0 is the last integrator and the last entry is
    // the fully differenced result
    cic_word_t comb_stage [CIC_ORDER+1];

    // Comb result waiting for the output register
    cic_word_t comb_out;
    logic comb_valid;

    // The modulator bit changes on the rising edge of its clock pin and
    // is only used two cycles later, well before the next bit strobe
    always_ff @(posedge clock) begin
        if (!reset) begin
            data_sync <= '0;
        end else begin
            data_sync <= {data_sync[0], data_in};
        end
    end

    // A one from the modulator counts as +1 and a zero as -1
    assign bit_value = data_sync[1] ? cic_word_t'(1) : cic_word_t'(-1);

    // Integrators run at the modulator bit rate. Each stage adds the
    // previous stage value from before this edge, which only adds a
    // fixed latency of a bit or two and leaves the gain unchanged.
    // Wraparound is intended, the combs undo it as long as the final
    // result fits the word.
    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < CIC_ORDER; i++) begin
                integ[i] <= '0;
            end
        end else if (bit_strobe) begin
            integ[0] <= integ[0] + bit_value;
            for (int i = 1; i < CIC_ORDER; i++) begin
                integ[i] <= integ[i] + integ[i-1];
            end
        end
    end

    // Each comb stage subtracts what its input was one frame ago
    always_comb begin
        comb_stage[0] = integ[CIC_ORDER-1];
        for (int i = 0; i < CIC_ORDER; i++) begin
            comb_stage[i+1] = comb_stage[i] - comb_delay[i];
        end
    end

    // Comb delays update once per frame. A clear from sync makes the next
    // sample a difference against zero, and drops a result in flight.
    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < CIC_ORDER; i++) begin
                comb_delay[i] <= '0;
            end
            comb_valid <= 1'b0;
        end else if (comb_clear) begin
            for (int i = 0; i < CIC_ORDER; i++) begin
                comb_delay[i] <= '0;
            end
            comb_valid <= 1'b0;
        end else begin
            comb_valid <= frame_strobe;
            if (frame_strobe) begin
                for (int i = 0; i < CIC_ORDER; i++) begin
                    comb_delay[i] <= comb_stage[i];
                end
            end
        end
    end

    // Result of the comb chain, captured with the delays
    always_ff @(posedge clock) begin
        if (frame_strobe) begin
            comb_out <= comb_stage[CIC_ORDER];
        end
    end

    // Output register, one cycle behind the combs, so the valid pulse
    // lands two cycles after the frame strobe
    always_ff @(posedge clock) begin
        if (comb_valid) begin
            sample <= {{(SAMPLE_WIDTH - CIC_WIDTH){comb_out[CIC_WIDTH-1]}}, comb_out};
        end
    end

    // Valid lasts one cycle, there is no handshake with the consumer
    always_ff @(posedge clock) begin
        if (!reset) begin
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= comb_valid;
        end
    end

endmodule : sd_cic_decimator

`default_nettype wire

// ==== logic/sd_clock_gen.sv ====
////////////////////////////////////////////////////////////////////////////
// Modulator clock pin and the bit and frame strobes shared by every
// decimator channel. A sync pulse restarts the period and the frame.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sd_clock_gen (
    input  logic clock,
    input  logic reset,
    input  logic sync,
    output logic clock_out,
    output logic bit_strobe,
    output logic frame_strobe
);

    import sd_pkg::*;

    // Current position in the modulator period, and where it goes next
    phase_t phase;
    phase_t phase_next;

    // Modulator bits already completed in the running frame
    bit_count_t bit_count;

    // High when the period reaches its last low cycle on this edge
    logic last_phase;

    // High when the bit finishing on this edge is the last of the frame
    logic last_bit;

    // The period wraps after its final phase, and sync forces the start
    // of a new period no matter where the counter stands
    always_comb begin
        if (sync || phase == phase_t'(MOD_PERIOD - 1)) begin
            phase_next = '0;
        end else begin
            phase_next = phase + 1'b1;
        end
    end

    // Bit strobe sits in the last low cycle of the period, so the pin has
    // been low for a while and the bit driven on the rising edge is stable
    assign last_phase = (phase_next == phase_t'(MOD_PERIOD - 1));
    assign last_bit = (bit_count == bit_count_t'(DECIMATION - 1));

    // All outputs are registered so the pin stays glitch free and the
    // strobes line up with the period counter
    always_ff @(posedge clock) begin
        if (!reset) begin
            // Parking the counter on the last phase makes the first edge
            // out of reset open a fresh period with the pin going high
            phase <= phase_t'(MOD_PERIOD - 1);
            bit_count <= '0;
            clock_out <= 1'b0;
            bit_strobe <= 1'b0;
            frame_strobe <= 1'b0;
        end else begin
            phase <= phase_next;

            // First half of the period drives the pin high
            clock_out <= (phase_next < phase_t'(MOD_PERIOD / 2));

            bit_strobe <= last_phase;

            // Frame closes on the strobe that completes bit 63
            frame_strobe <= last_phase && last_bit;

            // Sync realigns the frame so the next frame strobe comes after
            // a full 64 bits, otherwise count each completed bit
            if (sync) begin
                bit_count <= '0;
            end else if (last_phase) begin
                bit_count <= bit_count + 1'b1;
            end
        end
    end

endmodule : sd_clock_gen

`default_nettype wire

// ==== logic/sd_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared timing constants, CIC widths and sample types for the
// sigma-delta front end. Modules import it inside their bodies.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package sd_pkg;

    // System clocks per modulator clock period, half high and half low
    localparam int MOD_PERIOD = 4;

    // Width of the counter that walks through one modulator period
    localparam int PHASE_WIDTH = $clog2(MOD_PERIOD);

    // Modulator bits that make up one output sample
    localparam int DECIMATION = 64;

    // Width of the bit counter inside one decimation frame
    localparam int BIT_COUNT_WIDTH = $clog2(DECIMATION);

    // Number of integrator stages, and of comb stages
    localparam int CIC_ORDER = 3;

    // Accumulator width, wide enough for a CIC gain of 64 cubed plus sign
    localparam int CIC_WIDTH = 20;

    // Width of the samples presented at the outputs
    localparam int SAMPLE_WIDTH = 24;

    // Position inside one modulator period
    typedef logic [PHASE_WIDTH-1:0] phase_t;

    // Integrator and comb registers, which wrap in two's complement
    typedef logic signed [CIC_WIDTH-1:0] cic_word_t;

    // Output sample, the CIC result sign-extended to the output width
    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

    // Modulator bit index inside one decimation frame
    typedef logic [BIT_COUNT_WIDTH-1:0] bit_count_t;

endpackage : sd_pkg

`default_nettype wire

// ==== logic/sd_processor.sv ====
////////////////////////////////////////////////////////////////////////////
// Top level of the multi-channel sigma-delta front end. One clock generator
// drives lockstep decimators, samples leave packed with channel 0 lowest.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sd_processor #(
    parameter int N_CHANNELS = 2
) (
    input  logic                                      clock,
    input  logic                                      reset,
    input  logic [N_CHANNELS-1:0]                     data_in,
    input  logic                                      sync,
    output logic                                      clock_out,
    output logic [N_CHANNELS*sd_pkg::SAMPLE_WIDTH-1:0] samples,
    output logic                                      sample_valid
);

    import sd_pkg::*;

    // Strobes shared by every channel
    logic bit_strobe;
    logic frame_strobe;

    // Per-channel valid pulses, identical since all channels run lockstep
    logic [N_CHANNELS-1:0] channel_valid;

    // Modulator clock pin and the decimation timing
    sd_clock_gen u_clock_gen (
        .clock        (clock),
        .reset        (reset),
        .sync         (sync),
        .clock_out    (clock_out),
        .bit_strobe   (bit_strobe),
        .frame_strobe (frame_strobe)
    );

    // One decimator per modulator input. Sync also clears the comb
    // delays so aligned front ends restart from the same state.
    for (genvar ch = 0; ch < N_CHANNELS; ch++) begin : g_channel
        sd_cic_decimator u_decimator (
            .clock        (clock),
            .reset        (reset),
            .data_in      (data_in[ch]),
            .bit_strobe   (bit_strobe),
            .frame_strobe (frame_strobe),
            .comb_clear   (sync),
            .sample       (samples[ch*SAMPLE_WIDTH +: SAMPLE_WIDTH]),
            .sample_valid (channel_valid[ch])
        );
    end

    // Channel 0 speaks for all of them
    assign sample_valid = channel_valid[0];

endmodule : sd_processor

`default_nettype wire

// ==== testbench/sd_processor_properties.sv ====
////////////////////////////////////////////////////////////////////////////
// Concurrent checks on the strobe spacing and output timing of the front
// end, bound into every instance of the top level.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sd_processor_properties (
    input logic clock,
    input logic reset,
    input logic sync,
    input logic clock_out,
    input logic bit_strobe,
    input logic frame_strobe,
    input logic sample_valid
);

    import sd_pkg::*;

    // A bit strobe repeats one period later unless sync restarted the period
    bit_strobe_period: assert property (@(posedge clock) disable iff (!reset)
        bit_strobe |-> ##MOD_PERIOD
            (bit_strobe || $past(sync, 1) || $past(sync, 2) || $past(sync, 3)))
        else $error("bit_strobe did not repeat after one modulator period");

    // Comb stage then output register, and sync drops a result in flight
    valid_after_frame: assert property (@(posedge clock) disable iff (!reset)
        frame_strobe && !sync |-> ##2 sample_valid)
        else $error("sample_valid missing two cycles after frame_strobe");

    valid_has_frame: assert property (@(posedge clock) disable iff (!reset)
        sample_valid |-> $past(frame_strobe, 2))
        else $error("sample_valid without a frame_strobe two cycles earlier");

    // Valid is a single-cycle pulse
    valid_single_cycle: assert property (@(posedge clock) disable iff (!reset)
        sample_valid |=> !sample_valid)
        else $error("sample_valid high on two consecutive cycles");

    // The pin is registered, so it is low the cycle after reset is seen
    pin_low_in_reset: assert property (@(posedge clock)
        !reset |=> !clock_out)
        else $error("clock_out high while reset is held");

endmodule : sd_processor_properties

bind sd_processor sd_processor_properties i_properties (
    .clock        (clock),
    .reset        (reset),
    .sync         (sync),
    .clock_out    (clock_out),
    .bit_strobe   (bit_strobe),
    .frame_strobe (frame_strobe),
    .sample_valid (sample_valid)
);

`default_nettype wire

// ==== testbench/sd_processor_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the sigma-delta front end. It drives modulator bitstreams,
// models the CIC per bit and compares every sample at each valid pulse.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sd_processor_tb;

    import sd_pkg::*;

    localparam int N_CHANNELS = 2;
    localparam int TIMEOUT_CYCLES = 600;
    localparam int FULL_SCALE = DECIMATION ** 3;
    localparam int MODE_CONSTANT = 0;
    localparam int MODE_RANDOM = 1;
    localparam int MODE_ALTERNATE = 2;

    // Reference state of one channel, integrators, comb delays and the last result
    typedef struct packed {
        cic_word_t i0;
        cic_word_t i1;
        cic_word_t i2;
        cic_word_t d0;
        cic_word_t d1;
        cic_word_t d2;
        cic_word_t result;
    } cic_model_t;

    logic                               clock;
    logic                               reset;
    logic [N_CHANNELS-1:0]              data_in;
    logic                               sync;
    logic                               clock_out;
    logic [N_CHANNELS*SAMPLE_WIDTH-1:0] samples;
    logic                               sample_valid;

    cic_model_t model [N_CHANNELS];

    // Expected sample vectors, one entry per frame, oldest first
    logic [N_CHANNELS*SAMPLE_WIDTH-1:0] expected_q [$];
    logic [N_CHANNELS*SAMPLE_WIDTH-1:0] last_samples;

    int   bit_in_frame;
    int   bit_total;
    int   cycle_count;
    int   sync_cycle;
    int   valid_cycle;
    int   check_count;
    int   error_count;
    int   test_count;
    int   test_start_errors;
    logic check_period;

    sd_processor #(
        .N_CHANNELS (N_CHANNELS)
    ) i_sd_processor (
        .clock        (clock),
        .reset        (reset),
        .data_in      (data_in),
        .sync         (sync),
        .clock_out    (clock_out),
        .samples      (samples),
        .sample_valid (sample_valid)
    );

    initial clock = 1'b0;
    always #20 clock = ~clock;

    // Free running cycle count, used to time the sync restart
    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
    end

    // One modulator bit through the CIC. Integrators add the previous
    // stage value held before the bit, and on the last bit of a frame the
    // combs read the integrators before that bit is added
    function automatic cic_model_t cic_reference(cic_model_t state, logic bit_in,
                                                 logic frame_end);
        cic_model_t next;
        cic_word_t  x;
        cic_word_t  c0;
        cic_word_t  c1;
        next = state;
        x = bit_in ? cic_word_t'(1) : cic_word_t'(-1);
        if (frame_end) begin
            c0 = state.i2 - state.d0;
            c1 = c0 - state.d1;
            next.result = c1 - state.d2;
            next.d0 = state.i2;
            next.d1 = c0;
            next.d2 = c1;
        end
        next.i0 = state.i0 + x;
        next.i1 = state.i1 + state.i0;
        next.i2 = state.i2 + state.i1;
        return next;
    endfunction

    task automatic abort_run(string reason);
        $display("timeout: %s", reason);
        $display("Finished with errors");
        $fatal(1, "simulation stopped after a timeout");
    endtask

    task automatic check_sample(int channel, sample_t actual, sample_t expected);
        check_count++;
        assert (actual === expected) else begin
            $display("error: samples[%0d] = %h, expected %h", channel, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_low(string name, logic value);
        check_count++;
        assert (value === 1'b0) else begin
            $display("error: %s = %h, expected 0", name, value);
            error_count++;
        end
    endtask

    task automatic finish_test(string name);
        test_count++;
        $display("test %0d %s: %s, %0d errors", test_count, name,
                 (error_count == test_start_errors) ? "passed" : "failed",
                 error_count - test_start_errors);
        test_start_errors = error_count;
    endtask

    // Waits for the next rising clock_out, then drives one bit per channel
    // on this falling edge and holds it for the whole modulator period
    task automatic drive_bit(int mode, logic with_sync);
        logic [N_CHANNELS-1:0]              bits;
        logic [N_CHANNELS*SAMPLE_WIDTH-1:0] expected;
        logic                               frame_end;
        int                                 cycles;
        cycles = 0;
        while (clock_out && cycles < TIMEOUT_CYCLES) begin
            @(negedge clock);
            cycles++;
        end
        while (!clock_out && cycles < TIMEOUT_CYCLES) begin
            @(negedge clock);
            cycles++;
        end
        if (cycles >= TIMEOUT_CYCLES) begin
            abort_run("clock_out stopped toggling");
        end
        // Falling edges between two rising clock_out give the period
        if (check_period) begin
            check_count++;
            assert (cycles == MOD_PERIOD) else begin
                $display("error: clock_out period = %h cycles, expected %h", cycles, MOD_PERIOD);
                error_count++;
            end
        end
        check_period = !with_sync;
        for (int ch = 0; ch < N_CHANNELS; ch++) begin
            case (mode)
                MODE_CONSTANT: bits[ch] = (ch == 0);
                MODE_RANDOM:   bits[ch] = ($urandom() % 2) != 0;
                default:       bits[ch] = bit_total[0] ^ ch[0];
            endcase
        end
        data_in = bits;
        // Sync restarts the frame here and clears the comb delays
        if (with_sync) begin
            sync = 1'b1;
            sync_cycle = cycle_count;
            bit_in_frame = 0;
            for (int ch = 0; ch < N_CHANNELS; ch++) begin
                model[ch].d0 = '0;
                model[ch].d1 = '0;
                model[ch].d2 = '0;
            end
        end
        bit_in_frame++;
        frame_end = (bit_in_frame == DECIMATION);
        for (int ch = 0; ch < N_CHANNELS; ch++) begin
            model[ch] = cic_reference(model[ch], bits[ch], frame_end);
            expected[ch*SAMPLE_WIDTH +: SAMPLE_WIDTH] = sample_t'(model[ch].result);
        end
        if (frame_end) begin
            bit_in_frame = 0;
            expected_q.push_back(expected);
        end
        bit_total++;
        if (with_sync) begin
            @(negedge clock);
            sync = 1'b0;
        end
    endtask

    task automatic run_bits(int count, int mode);
        repeat (count) drive_bit(mode, 1'b0);
    endtask

    // Keeps the bitstream going in the given mode until every expected
    // sample has been compared, so every modulator period gets a fresh bit
    task automatic wait_for_samples(int mode);
        int bits;
        bits = 0;
        while (expected_q.size() != 0 && bits < TIMEOUT_CYCLES / MOD_PERIOD) begin
            drive_bit(mode, 1'b0);
            bits++;
        end
        if (expected_q.size() != 0) begin
            abort_run("expected samples never arrived");
        end
    endtask

    // Compares every valid sample with the oldest expected one
    initial begin : compare_samples
        logic [N_CHANNELS*SAMPLE_WIDTH-1:0] expected;
        int                                 cycles;
        forever begin
            cycles = 0;
            @(negedge clock);
            while (!(reset && sample_valid) && cycles < TIMEOUT_CYCLES) begin
                @(negedge clock);
                cycles++;
            end
            if (cycles >= TIMEOUT_CYCLES) begin
                abort_run("sample_valid did not pulse");
            end
            check_count++;
            assert (expected_q.size() != 0) else begin
                $display("sample_valid pulsed when no sample was expected");
                error_count++;
            end
            if (expected_q.size() != 0) begin
                expected = expected_q[0];
                last_samples = samples;
                valid_cycle = cycle_count;
                for (int ch = 0; ch < N_CHANNELS; ch++) begin
                    check_sample(ch, samples[ch*SAMPLE_WIDTH +: SAMPLE_WIDTH],
                                 expected[ch*SAMPLE_WIDTH +: SAMPLE_WIDTH]);
                end
                void'(expected_q.pop_front());
            end
        end
    end

    initial begin : run_tests
        sample_t settled;
        void'($urandom(99));
        reset = 1'b0;
        sync = 1'b0;
        data_in = '0;
        cycle_count = 0;
        bit_in_frame = 0;
        bit_total = 0;
        check_count = 0;
        error_count = 0;
        test_count = 0;
        test_start_errors = 0;
        check_period = 1'b0;
        for (int ch = 0; ch < N_CHANNELS; ch++) begin
            model[ch] = '0;
        end

        // Pin and valid must stay low for the whole reset
        repeat (3) begin
            @(negedge clock);
            check_low("clock_out", clock_out);
            check_low("sample_valid", sample_valid);
        end
        reset = 1'b1;
        run_bits(16, MODE_CONSTANT);
        finish_test("reset and clock_out period");

        // Full scale needs three frames to fill the combs
        run_bits(6 * DECIMATION - 16, MODE_CONSTANT);
        wait_for_samples(MODE_CONSTANT);
        for (int ch = 0; ch < N_CHANNELS; ch++) begin
            check_sample(ch, last_samples[ch*SAMPLE_WIDTH +: SAMPLE_WIDTH],
                         (ch == 0) ? sample_t'(FULL_SCALE) : sample_t'(-FULL_SCALE));
        end
        finish_test("constant full scale");

        run_bits(20 * DECIMATION, MODE_RANDOM);
        wait_for_samples(MODE_RANDOM);
        finish_test("random bitstreams");

        // Alternating bits sit in the CIC null, so the output settles near zero
        run_bits(6 * DECIMATION, MODE_ALTERNATE);
        wait_for_samples(MODE_ALTERNATE);
        for (int ch = 0; ch < N_CHANNELS; ch++) begin
            settled = last_samples[ch*SAMPLE_WIDTH +: SAMPLE_WIDTH];
            check_count++;
            assert (settled >= -64 && settled <= 64) else begin
                $display("error: samples[%0d] = %h, expected a value near zero", ch, settled);
                error_count++;
            end
        end
        finish_test("alternating pattern");

        // Sync lands mid-frame, then one full frame of bits follows it
        run_bits(30, MODE_RANDOM);
        drive_bit(MODE_RANDOM, 1'b1);
        run_bits(DECIMATION - 1, MODE_RANDOM);
        wait_for_samples(MODE_RANDOM);
        check_count++;
        assert (valid_cycle - sync_cycle == MOD_PERIOD * DECIMATION + 2) else begin
            $display("error: sample_valid came %h cycles after sync, expected %h",
                     valid_cycle - sync_cycle, MOD_PERIOD * DECIMATION + 2);
            error_count++;
        end
        finish_test("sync restart");

        $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : sd_processor_tb

`default_nettype wire
